//--- verilog/fetchPkg.sv
`default_nettype none

package fetchPkg;

    // ############################
    // Fetch constants.
    // ############################

    localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

    // Opcodes.
    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_REGIMM = 6'h01;  // BLTZ, BGEZ and friends.
    localparam logic [5:0] OP_J      = 6'h02;
    localparam logic [5:0] OP_JAL    = 6'h03;
    localparam logic [5:0] OP_BEQ    = 6'h04;
    localparam logic [5:0] OP_BNE    = 6'h05;
    localparam logic [5:0] OP_BLEZ   = 6'h06;
    localparam logic [5:0] OP_BGTZ   = 6'h07;

    // Function codes for register jumps.
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;

    // ############################
    // Queue and credit sizing.
    // ############################

    localparam int FETCH_QUEUE_DEPTH = 4;
    localparam int DECODE_CREDITS    = 4;

    localparam int FETCH_CREDIT_W  = $clog2(FETCH_QUEUE_DEPTH + 1);
    localparam int DECODE_CREDIT_W = $clog2(DECODE_CREDITS + 1);

    // One fetched word on its way to decode.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;           // Zero on address error.
        logic        delaySlotOwner;
        logic        addrError;
        logic [31:0] badVaddr;
    } fetchEntryT;

endpackage

`default_nettype wire

//--- verilog/fetchLinkIf.sv
`timescale 1ns/1ps
`default_nettype none

interface fetchLinkIf;
    import fetchPkg::*;

    logic       entryValid;
    fetchEntryT entry;
    logic       creditReturn;  // One pulse per freed slot.

    modport producer (
        output entryValid,
        output entry,
        input  creditReturn
    );

    modport consumer (
        input  entryValid,
        input  entry,
        output creditReturn
    );

endinterface

`default_nettype wire

//--- verilog/pcFetch.sv
`timescale 1ns/1ps
`default_nettype none

module pcFetch (
    input  logic         clk,
    input  logic         resetn,
    input  logic         flush,
    input  logic [31:0]  flushPc,
    input  logic         redirectValid,
    input  logic [31:0]  redirectPc,
    input  logic [31:0]  redirectInstr,
    input  logic [31:0]  redirectReg,
    input  logic         branchTaken,
    output logic         ireqValid,
    output logic [31:0]  ireqAddr,
    fetchLinkIf.producer respLink,
    fetchLinkIf.consumer creditIn
);
    import fetchPkg::*;

    logic [FETCH_CREDIT_W-1:0] fetchCredits;
    logic                      fetchEn;       // Low only in the reset cycle.
    logic [31:0]               seqPc;
    logic                      targetValid;
    logic [31:0]               targetPc;
    logic                      issue;
    logic [31:0]               issueAddr;
    logic                      misaligned;
    logic [5:0]                op;
    logic [5:0]                funct;
    logic [31:0]               redirectPlus4;
    logic [31:0]               signImm;
    logic [31:0]               jumpTarget;
    logic [31:0]               branchTarget;
    logic                      redirectHit;
    logic [31:0]               redirectTarget;

    // ############################
    // Redirect decode.
    // ############################

    assign op            = redirectInstr[31:26];
    assign funct         = redirectInstr[5:0];
    assign redirectPlus4 = redirectPc + 32'd4;
    assign signImm       = {{16{redirectInstr[15]}}, redirectInstr[15:0]};
    assign jumpTarget    = {redirectPlus4[31:28], redirectInstr[25:0], 2'b00};
    assign branchTarget  = redirectPlus4 + {signImm[29:0], 2'b00};

    always_comb begin
        redirectHit    = 1'b0;
        redirectTarget = jumpTarget;
        if (redirectValid) begin
            if (op == OP_J || op == OP_JAL) begin
                redirectHit = 1'b1;
            end else if (op == OP_RTYPE && (funct == FN_JR || funct == FN_JALR)) begin
                redirectHit    = 1'b1;
                redirectTarget = redirectReg;
            end else if (branchTaken) begin
                redirectHit    = 1'b1;
                redirectTarget = branchTarget;
            end
        end
    end

    // ############################
    // Issue.
    // ############################

    assign issue      = fetchEn && (fetchCredits != '0) && !flush;
    assign issueAddr  = targetValid ? targetPc : seqPc;
    assign misaligned = issueAddr[1:0] != 2'b00;

    assign ireqValid = issue && !misaligned;  // Bad address never reaches the bus.
    assign ireqAddr  = issueAddr;

    assign respLink.entryValid = issue;

    always_comb begin
        respLink.entry           = '0;
        respLink.entry.pc        = issueAddr;
        respLink.entry.addrError = misaligned;
        respLink.entry.badVaddr  = misaligned ? issueAddr : 32'd0;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetchEn      <= 1'b0;
            seqPc        <= RESET_VECTOR;
            targetValid  <= 1'b0;
            fetchCredits <= FETCH_CREDIT_W'(FETCH_QUEUE_DEPTH);
        end else begin
            fetchEn <= 1'b1;
            if (flush) begin
                seqPc        <= flushPc;
                targetValid  <= 1'b0;
                fetchCredits <= FETCH_CREDIT_W'(FETCH_QUEUE_DEPTH);  // Queue and pipe empty.
            end else begin
                if (issue) begin
                    seqPc <= issueAddr + 32'd4;
                end
                if (redirectHit) begin
                    targetValid <= 1'b1;
                end else if (issue) begin
                    targetValid <= 1'b0;  // Target consumed.
                end
                fetchCredits <= fetchCredits - FETCH_CREDIT_W'(issue)
                              + FETCH_CREDIT_W'(creditIn.creditReturn);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirectHit) begin
            targetPc <= redirectTarget;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetchAlign.sv
`timescale 1ns/1ps
`default_nettype none

module fetchAlign (
    input  logic         clk,
    input  logic         resetn,
    input  logic         flush,
    input  logic [31:0]  irespData,
    fetchLinkIf.consumer respLink,
    fetchLinkIf.producer queueLink
);
    import fetchPkg::*;

    logic       pendValid;
    fetchEntryT pendEntry;
    fetchEntryT alignedEntry;
    logic [31:0] instr;
    logic [5:0]  op;
    logic [5:0]  funct;
    logic        isBranch;
    logic        isJump;

    // No slots to return toward pcFetch.
    assign respLink.creditReturn = 1'b0;

    // ############################
    // Request side.
    // ############################

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pendValid <= 1'b0;
        end else begin
            pendValid <= respLink.entryValid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        pendEntry <= respLink.entry;
    end

    // ############################
    // Response and predecode.
    // ############################

    assign instr = pendEntry.addrError ? 32'd0 : irespData;
    assign op    = instr[31:26];
    assign funct = instr[5:0];

    assign isBranch = op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM};
    assign isJump   = (op == OP_J) || (op == OP_JAL)
                   || (op == OP_RTYPE && (funct == FN_JR || funct == FN_JALR));

    always_comb begin
        alignedEntry                = pendEntry;
        alignedEntry.instr          = instr;
        alignedEntry.delaySlotOwner = isBranch || isJump;  // Zero word never owns one.
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            queueLink.entryValid <= 1'b0;
        end else begin
            queueLink.entryValid <= pendValid && !flush;  // Killed in flight.
        end
    end

    always_ff @(posedge clk) begin
        queueLink.entry <= alignedEntry;
    end

endmodule

`default_nettype wire

//--- verilog/creditQueue.sv
`timescale 1ns/1ps
`default_nettype none

module creditQueue #(
    parameter int depth = fetchPkg::FETCH_QUEUE_DEPTH
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 flush,
    input  logic                 decodeCredit,
    fetchLinkIf.consumer         queueLink,
    output logic                 fetchValid,
    output fetchPkg::fetchEntryT fetchEntry
);
    import fetchPkg::*;

    typedef logic [$clog2(depth)-1:0]   ptrT;
    typedef logic [$clog2(depth+1)-1:0] countT;

    fetchEntryT                 mem [depth];
    ptrT                        head;
    ptrT                        tail;
    countT                      count;
    logic [DECODE_CREDIT_W-1:0] decCredits;
    logic                       push;
    logic                       pop;

    function automatic ptrT nextPtr(input ptrT p);
        return (p == ptrT'(depth - 1)) ? '0 : p + ptrT'(1);
    endfunction

    // ############################
    // Output toward decode.
    // ############################

    assign fetchValid = (count != '0) && (decCredits != '0) && !flush;
    assign fetchEntry = mem[head];

    // Slot freed as the entry leaves.
    assign queueLink.creditReturn = fetchValid;

    assign push = queueLink.entryValid && !flush;
    assign pop  = fetchValid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= queueLink.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= nextPtr(tail);
            end
            if (pop) begin
                head <= nextPtr(head);
            end
            count <= count + countT'(push) - countT'(pop);
        end
    end

    // Decode credits survive a flush.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            decCredits <= DECODE_CREDIT_W'(DECODE_CREDITS);
        end else begin
            decCredits <= decCredits - DECODE_CREDIT_W'(pop)
                        + DECODE_CREDIT_W'(decodeCredit);
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetchTop.sv
`timescale 1ns/1ps
`default_nettype none

module fetchTop (
    input  logic        clk,
    input  logic        resetn,
    input  logic        flush,
    input  logic [31:0] flushPc,
    input  logic        redirectValid,
    input  logic [31:0] redirectPc,
    input  logic [31:0] redirectInstr,
    input  logic [31:0] redirectReg,
    input  logic        branchTaken,
    input  logic [31:0] irespData,
    input  logic        decodeCredit,
    output logic        ireqValid,
    output logic [31:0] ireqAddr,
    output logic        fetchValid,
    output logic [31:0] fetchPc,
    output logic [31:0] fetchInstr,
    output logic        fetchDelaySlot,
    output logic        fetchAddrError,
    output logic [31:0] fetchBadVaddr
);
    import fetchPkg::*;

    fetchEntryT fetchEntry;

    fetchLinkIf respLink ();
    fetchLinkIf queueLink ();

    pcFetch uPcFetch (
        .clk           (clk),
        .resetn        (resetn),
        .flush         (flush),
        .flushPc       (flushPc),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .redirectInstr (redirectInstr),
        .redirectReg   (redirectReg),
        .branchTaken   (branchTaken),
        .ireqValid     (ireqValid),
        .ireqAddr      (ireqAddr),
        .respLink      (respLink),
        .creditIn      (queueLink)  // Credit return only.
    );

    fetchAlign uFetchAlign (
        .clk       (clk),
        .resetn    (resetn),
        .flush     (flush),
        .irespData (irespData),
        .respLink  (respLink),
        .queueLink (queueLink)
    );

    creditQueue #(
        .depth (FETCH_QUEUE_DEPTH)
    ) uCreditQueue (
        .clk          (clk),
        .resetn       (resetn),
        .flush        (flush),
        .decodeCredit (decodeCredit),
        .queueLink    (queueLink),
        .fetchValid   (fetchValid),
        .fetchEntry   (fetchEntry)
    );

    // Entry fields out to decode.
    assign fetchPc        = fetchEntry.pc;
    assign fetchInstr     = fetchEntry.instr;
    assign fetchDelaySlot = fetchEntry.delaySlotOwner;
    assign fetchAddrError = fetchEntry.addrError;
    assign fetchBadVaddr  = fetchEntry.badVaddr;

endmodule

`default_nettype wire

//--- testbench/fetchTop_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fetchTop_sva (
    input logic        clk,
    input logic        resetn,
    input logic        flush,
    input logic        decodeCredit,
    input logic        fetchIssue,
    input logic        ireqValid,
    input logic [31:0] ireqAddr,
    input logic        fetchValid
);
    import fetchPkg::*;

    int failures = 0;
    int fetchLeft;
    int decodeLeft;

    // Credits counted from the link handshakes alone.
    always @(posedge clk) begin
        if (!resetn) begin
            fetchLeft  <= FETCH_QUEUE_DEPTH;
            decodeLeft <= DECODE_CREDITS;
        end else begin
            if (flush) begin
                fetchLeft <= FETCH_QUEUE_DEPTH;  // Queue and pipe empty.
            end else begin
                fetchLeft <= fetchLeft - int'(fetchIssue) + int'(fetchValid);
            end
            decodeLeft <= decodeLeft - int'(fetchValid) + int'(decodeCredit);
        end
    end

    noIssueWithoutCredit: assert property (@(posedge clk) disable iff (!resetn)
        ireqValid |-> fetchLeft > 0)
        else begin
            failures++;
            $error("Bus request issued with no fetch credits");
        end

    noEntryWithoutCredit: assert property (@(posedge clk) disable iff (!resetn)
        fetchValid |-> decodeLeft > 0)
        else begin
            failures++;
            $error("Entry sent to decode with no decode credits");
        end

    // Misaligned fetches become error entries instead.
    alignedRequest: assert property (@(posedge clk) disable iff (!resetn)
        ireqValid |-> ireqAddr[1:0] == 2'b00)
        else begin
            failures++;
            $error("Bus request with a misaligned address");
        end

endmodule

bind fetchTop fetchTop_sva svaChecks (
    .clk          (clk),
    .resetn       (resetn),
    .flush        (flush),
    .decodeCredit (decodeCredit),
    .fetchIssue   (respLink.entryValid),
    .ireqValid    (ireqValid),
    .ireqAddr     (ireqAddr),
    .fetchValid   (fetchValid)
);

`default_nettype wire

//--- testbench/fetchChecker.sv
`timescale 1ns/1ps
`default_nettype none

module fetchChecker (
    input  logic        clk,
    input  logic        resetn,
    input  logic        flush,
    input  logic        redirectValid,
    input  logic        branchTaken,
    input  logic        decodeCredit,
    input  logic [31:0] flushPc,
    input  logic [31:0] redirectPc,
    input  logic [31:0] redirectInstr,
    input  logic [31:0] redirectReg,
    input  logic [31:0] irespData,
    input  logic        ireqValid,
    input  logic [31:0] ireqAddr,
    input  logic        fetchValid,
    input  logic [31:0] fetchPc,
    input  logic [31:0] fetchInstr,
    input  logic        fetchDelaySlot,
    input  logic        fetchAddrError,
    input  logic [31:0] fetchBadVaddr,
    output int          mismatches,
    output int          entriesChecked
);
    import fetchPkg::*;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        err;
    } expEntryT;

    expEntryT    expQ [$];
    expEntryT    waiting;       // Issued last cycle, data arrives now.
    logic        waitValid;
    logic        enabled;
    int          fetchCredits;
    int          decCredits;
    logic [31:0] seqPc;
    logic [31:0] heldTarget;
    logic        heldValid;

    function automatic logic ownsDelaySlot(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM, OP_J, OP_JAL}) begin
            return 1'b1;
        end
        return op == OP_RTYPE && (w[5:0] == FN_JR || w[5:0] == FN_JALR);
    endfunction

    // Hit flag on top, target below.
    function automatic logic [32:0] targetOf(input logic [31:0] pc, input logic [31:0] instr,
                                             input logic [31:0] regVal, input logic taken);
        logic [31:0] link;
        link = pc + 32'd4;
        if (instr[31:26] == OP_J || instr[31:26] == OP_JAL) begin
            return {1'b1, link[31:28], instr[25:0], 2'b00};
        end else if (instr[31:26] == OP_RTYPE && (instr[5:0] == FN_JR || instr[5:0] == FN_JALR)) begin
            return {1'b1, regVal};
        end else if (taken) begin
            return {1'b1, link + {{14{instr[15]}}, instr[15:0], 2'b00}};
        end
        return 33'd0;
    endfunction

    task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        mismatches     = 0;
        entriesChecked = 0;
    end

    // ##############################
    // Cycle model, sampled mid-cycle.
    // ##############################

    always @(negedge clk) begin : model
        expEntryT    e;
        logic [32:0] hit;
        logic [31:0] addr;
        logic        issue;
        if (!resetn) begin
            expQ.delete();
            waitValid    = 1'b0;
            heldValid    = 1'b0;
            seqPc        = RESET_VECTOR;
            fetchCredits = FETCH_QUEUE_DEPTH;
            decCredits   = DECODE_CREDITS;
        end else begin
            if (waitValid) begin
                if (!waiting.err) begin
                    waiting.instr = irespData;
                end
                expQ.push_back(waiting);
                waitValid = 1'b0;
            end
            if (flush) begin
                expQ.delete();  // Everything older is killed.
            end
            if (fetchValid) begin
                if (decCredits == 0) begin
                    mismatches++;
                    $display("Mismatch at %0t: entry sent with no decode credit", $time);
                end
                if (expQ.size() == 0) begin
                    mismatches++;
                    $display("Mismatch at %0t: unexpected entry at pc %h", $time, fetchPc);
                end else begin
                    e = expQ.pop_front();
                    expectEq("fetchPc", fetchPc, e.pc);
                    expectEq("fetchInstr", fetchInstr, e.instr);
                    expectEq("fetchDelaySlot", 32'(fetchDelaySlot), 32'(ownsDelaySlot(e.instr)));
                    expectEq("fetchAddrError", 32'(fetchAddrError), 32'(e.err));
                    expectEq("fetchBadVaddr", fetchBadVaddr, e.err ? e.pc : 32'd0);
                    entriesChecked++;
                end
            end
            decCredits += int'(decodeCredit) - int'(fetchValid);

            issue = enabled && fetchCredits > 0 && !flush;
            addr  = heldValid ? heldTarget : seqPc;
            expectEq("ireqValid", 32'(ireqValid), 32'(issue && addr[1:0] == 2'b00));
            if (issue && addr[1:0] == 2'b00) begin
                expectEq("ireqAddr", ireqAddr, addr);
            end
            if (issue) begin
                waiting.pc    = addr;
                waiting.instr = 32'd0;
                waiting.err   = addr[1:0] != 2'b00;
                waitValid     = 1'b1;
            end
            fetchCredits += int'(fetchValid) - int'(issue);

            hit = targetOf(redirectPc, redirectInstr, redirectReg, branchTaken);
            if (flush) begin
                seqPc        = flushPc;
                heldValid    = 1'b0;
                fetchCredits = FETCH_QUEUE_DEPTH;
            end else begin
                if (issue) begin
                    seqPc = addr + 32'd4;
                end
                if (redirectValid && hit[32]) begin
                    heldValid  = 1'b1;
                    heldTarget = hit[31:0];
                end else if (issue) begin
                    heldValid = 1'b0;
                end
            end
        end
        enabled = resetn;  // Fetch starts one cycle after reset ends.
    end

endmodule

`default_nettype wire

//--- testbench/tb_fetchTop.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetchTop;
    import fetchPkg::*;

    localparam logic [31:0] SEED          = 32'he573_b5e0;
    localparam int          PERIOD        = 100;
    localparam int          RANDOM_CYCLES = 4000;
    localparam int          WAIT_LIMIT    = 200;
    localparam logic [31:0] IDLE_WORD     = 32'h1000_0000;  // A BEQ, so stray use shows.

    logic        clk;
    logic        resetn;
    logic        flush;
    logic        redirectValid;
    logic        branchTaken;
    logic        decodeCredit;
    logic [31:0] flushPc;
    logic [31:0] redirectPc;
    logic [31:0] redirectInstr;
    logic [31:0] redirectReg;
    logic [31:0] irespData;
    logic        ireqValid;
    logic [31:0] ireqAddr;
    logic        fetchValid;
    logic [31:0] fetchPc;
    logic [31:0] fetchInstr;
    logic        fetchDelaySlot;
    logic        fetchAddrError;
    logic [31:0] fetchBadVaddr;
    logic [31:0] respNext;
    int          mismatches;
    int          entriesChecked;
    int          otherErrors;
    int          received = 0;
    int          credited;

    fetchTop dut_i (.*);
    fetchChecker chk (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    // Every address bit feeds the word.
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ 32'h9E37_79B9;
        h = h ^ (h >> 15);
        h = h * 32'h2C1B_3C6D;
        return h ^ (h >> 12);
    endfunction

    // ##############################
    // Instruction memory and decode.
    // ##############################

    always @(negedge clk) begin
        respNext = (ireqValid === 1'b1) ? memWord(ireqAddr) : IDLE_WORD;
        if (resetn && fetchValid === 1'b1) begin
            received++;
        end
    end

    task automatic stepCycle(input int creditPct);
        @(posedge clk);
        #1;
        irespData     = respNext;
        flush         = 1'b0;
        redirectValid = 1'b0;
        branchTaken   = 1'b0;
        decodeCredit  = 1'b0;
        if (received > credited && $urandom_range(99) < creditPct) begin
            decodeCredit = 1'b1;
            credited++;
        end
    endtask

    task automatic randomRedirect();
        int kind;
        kind          = $urandom_range(4);
        redirectValid = 1'b1;
        redirectPc    = $urandom & 32'hFFFF_FFFC;
        redirectReg   = $urandom & 32'hFFFF_FFFC;
        case (kind)
            0: redirectInstr = {($urandom_range(1) ? OP_JAL : OP_J), 26'($urandom)};
            1: begin
                redirectInstr = {OP_RTYPE, 20'($urandom), ($urandom_range(1) ? FN_JALR : FN_JR)};
                if ($urandom_range(3) == 0) begin
                    redirectReg[1:0] = 2'($urandom_range(3, 1));  // Address error ahead.
                end
            end
            2, 3: begin
                redirectInstr = {($urandom_range(1) ? OP_BNE : OP_BEQ), 26'($urandom)};
                branchTaken   = (kind == 2);
            end
            default: redirectInstr = {6'h08, 26'($urandom)};  // ADDI.
        endcase
    endtask

    initial begin : stimulus
        int cycle;
        int waited;
        void'($urandom(SEED));
        resetn        = 1'b0;
        flush         = 1'b0;
        flushPc       = 32'd0;
        redirectValid = 1'b0;
        redirectPc    = 32'd0;
        redirectInstr = 32'd0;
        redirectReg   = 32'd0;
        branchTaken   = 1'b0;
        irespData     = 32'd0;
        decodeCredit  = 1'b0;
        credited      = 0;
        otherErrors   = 0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;

        for (cycle = 0; cycle < RANDOM_CYCLES; cycle++) begin
            stepCycle((cycle % 400) < 60 ? 0 : 70);  // Periodic credit starvation.
            if ($urandom_range(99) < 6) begin
                randomRedirect();
            end
            if ($urandom_range(299) == 0) begin
                flush   = 1'b1;
                flushPc = $urandom & 32'hFFFF_FFFC;
            end
        end

        // Decode withholds all credits.
        for (cycle = 0; cycle < 40; cycle++) begin
            stepCycle(0);
            if (cycle >= 30 && (ireqValid || fetchValid)) begin
                otherErrors++;
                $display("Fetch kept running at %0t while decode credits were withheld", $time);
            end
        end
        if (received - credited > DECODE_CREDITS) begin
            otherErrors++;
            $display("More entries outstanding at decode than it has credits for");
        end

        waited = 0;
        do begin
            stepCycle(100);
            waited++;
        end while (!fetchValid && waited < WAIT_LIMIT);
        if (!fetchValid) begin
            otherErrors++;
            $display("Timed out waiting for entries after decode credits resumed");
        end
        repeat (100) stepCycle(100);

        if (entriesChecked < 500) begin
            otherErrors++;
            $display("Only %0d entries reached decode", entriesChecked);
        end
        $display("Checked %0d entries: %0d mismatches, %0d assertion failures, %0d other errors",
                 entriesChecked, mismatches, dut_i.svaChecks.failures, otherErrors);
        if (mismatches == 0 && otherErrors == 0 && dut_i.svaChecks.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/fetchPkg.sv
verilog/fetchLinkIf.sv
verilog/pcFetch.sv
verilog/fetchAlign.sv
verilog/creditQueue.sv
verilog/fetchTop.sv
testbench/fetchTop_sva.sv
testbench/fetchChecker.sv
testbench/tb_fetchTop.sv
